// ==== hw/wiscPkg.sv ====
`default_nettype none

package wiscPkg;

	// datapath widths
	localparam int dataWidth = 16;
	localparam int instrWidth = 16;
	localparam int regSelWidth = 3;

	// instruction field widths
	localparam int opWidth = 5;
	localparam int functWidth = 2;
	localparam int imm5Width = 5;
	localparam int imm8Width = 8;
	localparam int disp11Width = 11;

	// special and control
	localparam logic [opWidth-1:0] opHalt = 5'b00000;
	localparam logic [opWidth-1:0] opNop = 5'b00001;

	// immediate arithmetic and logic
	localparam logic [opWidth-1:0] opAddi = 5'b01000;
	localparam logic [opWidth-1:0] opSubi = 5'b01001;
	localparam logic [opWidth-1:0] opXori = 5'b01010;
	localparam logic [opWidth-1:0] opAndni = 5'b01011;

	// immediate shifts and rotates
	localparam logic [opWidth-1:0] opRoli = 5'b10100;
	localparam logic [opWidth-1:0] opSlli = 5'b10101;
	localparam logic [opWidth-1:0] opRori = 5'b10110;
	localparam logic [opWidth-1:0] opSrli = 5'b10111;

	// memory and byte loads
	localparam logic [opWidth-1:0] opSt = 5'b10000;
	localparam logic [opWidth-1:0] opLd = 5'b10001;
	localparam logic [opWidth-1:0] opStu = 5'b10011;
	localparam logic [opWidth-1:0] opSlbi = 5'b10010;
	localparam logic [opWidth-1:0] opLbi = 5'b11000;

	// register-register group
	localparam logic [opWidth-1:0] opBtr = 5'b11001;
	localparam logic [opWidth-1:0] opAlu = 5'b11011;
	localparam logic [opWidth-1:0] opShift = 5'b11010;
	localparam logic [opWidth-1:0] opSeq = 5'b11100;
	localparam logic [opWidth-1:0] opSlt = 5'b11101;
	localparam logic [opWidth-1:0] opSle = 5'b11110;
	localparam logic [opWidth-1:0] opSco = 5'b11111;

	// branches on rs
	localparam logic [opWidth-1:0] opBeqz = 5'b01100;
	localparam logic [opWidth-1:0] opBnez = 5'b01101;
	localparam logic [opWidth-1:0] opBltz = 5'b01110;
	localparam logic [opWidth-1:0] opBgez = 5'b01111;

	// jumps, the 0011x pair links through R7
	localparam logic [opWidth-1:0] opJ = 5'b00100;
	localparam logic [opWidth-1:0] opJr = 5'b00101;
	localparam logic [opWidth-1:0] opJal = 5'b00110;
	localparam logic [opWidth-1:0] opJalr = 5'b00111;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [regSelWidth-1:0] rs;
		logic [regSelWidth-1:0] rt;
		logic [regSelWidth-1:0] rd;
		logic [functWidth-1:0] funct;
	} rFormT;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [regSelWidth-1:0] rs;
		logic [regSelWidth-1:0] rd;
		logic [imm5Width-1:0] imm5;
	} iForm1T;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [regSelWidth-1:0] rs;
		logic [imm8Width-1:0] imm8;
	} iForm2T;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [disp11Width-1:0] disp11;
	} jFormT;

	// one word, four views
	typedef union packed {
		rFormT rForm;
		iForm1T iForm1;
		iForm2T iForm2;
		jFormT jForm;
	} instrWord;

endpackage

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input wire [wiscPkg::instrWidth-1:0] instr,
	output logic [wiscPkg::opWidth-1:0] opcode,
	output logic [wiscPkg::regSelWidth-1:0] rsSel,
	output logic [wiscPkg::regSelWidth-1:0] rtSel,
	output logic [wiscPkg::regSelWidth-1:0] writeSel,
	output logic [wiscPkg::functWidth-1:0] aluOp,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic savePC,
	output logic halt,
	output logic nop
);

	// link register for jal and jalr
	localparam logic [wiscPkg::regSelWidth-1:0] linkReg = '1;

	wiscPkg::instrWord word;

	assign word = instr;

	// fixed fields straight off the word
	assign opcode = word.rForm.opcode;
	assign rsSel = word.rForm.rs;
	assign rtSel = word.rForm.rt;
	assign aluOp = word.rForm.funct;

	assign halt = (opcode == wiscPkg::opHalt);
	assign nop = (opcode == wiscPkg::opNop);

	always_comb begin
		// nothing written, no memory access
		regWrite = 1'b0;
		writeSel = '0;
		memRead = 1'b0;
		memWrite = 1'b0;
		savePC = 1'b0;

		case (opcode)
			// register-register ops write rd at bits 4:2
			wiscPkg::opBtr,
			wiscPkg::opAlu,
			wiscPkg::opShift,
			wiscPkg::opSeq,
			wiscPkg::opSlt,
			wiscPkg::opSle,
			wiscPkg::opSco: begin
				regWrite = 1'b1;
				writeSel = word.rForm.rd;
			end

			// i-format 1 ops write rd at bits 7:5
			wiscPkg::opAddi,
			wiscPkg::opSubi,
			wiscPkg::opXori,
			wiscPkg::opAndni,
			wiscPkg::opRoli,
			wiscPkg::opSlli,
			wiscPkg::opRori,
			wiscPkg::opSrli: begin
				regWrite = 1'b1;
				writeSel = word.iForm1.rd;
			end

			wiscPkg::opLd: begin
				regWrite = 1'b1;
				writeSel = word.iForm1.rd;
				memRead = 1'b1;
			end

			wiscPkg::opSt: begin
				memWrite = 1'b1;
			end

			// store with update writes the address back into rs
			wiscPkg::opStu: begin
				memWrite = 1'b1;
				regWrite = 1'b1;
				writeSel = word.iForm2.rs;
			end

			wiscPkg::opLbi,
			wiscPkg::opSlbi: begin
				regWrite = 1'b1;
				writeSel = word.iForm2.rs;
			end

			// return address goes to R7
			wiscPkg::opJal,
			wiscPkg::opJalr: begin
				regWrite = 1'b1;
				writeSel = linkReg;
				savePC = 1'b1;
			end

			default: begin
				regWrite = 1'b0;
			end
		endcase

		// a single memory port cannot read and write in one cycle
		assert (!(memRead && memWrite))
			else $error("opcode %b raises memRead and memWrite together", opcode);
	end

endmodule

`default_nettype wire

// ==== hw/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen #(
	parameter int dataWidth = wiscPkg::dataWidth
) (
	input wire [wiscPkg::instrWidth-1:0] instr,
	output logic [dataWidth-1:0] imm
);

	wiscPkg::instrWord word;
	logic [wiscPkg::imm5Width-1:0] imm5;
	logic [wiscPkg::imm8Width-1:0] imm8;
	logic [wiscPkg::disp11Width-1:0] disp11;
	logic [dataWidth-1:0] imm5Zext;
	logic [dataWidth-1:0] imm5Sext;
	logic [dataWidth-1:0] imm8Zext;
	logic [dataWidth-1:0] imm8Sext;
	logic [dataWidth-1:0] disp11Sext;

	assign word = instr;

	// same word seen through three views
	assign imm5 = word.iForm1.imm5;
	assign imm8 = word.iForm2.imm8;
	assign disp11 = word.jForm.disp11;

	assign imm5Zext = {{(dataWidth - wiscPkg::imm5Width){1'b0}}, imm5};
	assign imm5Sext = {{(dataWidth - wiscPkg::imm5Width){imm5[wiscPkg::imm5Width-1]}}, imm5};
	assign imm8Zext = {{(dataWidth - wiscPkg::imm8Width){1'b0}}, imm8};
	assign imm8Sext = {{(dataWidth - wiscPkg::imm8Width){imm8[wiscPkg::imm8Width-1]}}, imm8};
	assign disp11Sext = {{(dataWidth - wiscPkg::disp11Width){disp11[wiscPkg::disp11Width-1]}},
		disp11};

	always_comb begin
		case (word.jForm.opcode)
			// logical immediates are unsigned
			wiscPkg::opXori,
			wiscPkg::opAndni: imm = imm5Zext;

			wiscPkg::opAddi,
			wiscPkg::opSubi,
			wiscPkg::opRoli,
			wiscPkg::opSlli,
			wiscPkg::opRori,
			wiscPkg::opSrli,
			wiscPkg::opSt,
			wiscPkg::opLd,
			wiscPkg::opStu: imm = imm5Sext;

			// low byte shifted in, keep it unsigned
			wiscPkg::opSlbi: imm = imm8Zext;

			wiscPkg::opLbi,
			wiscPkg::opBeqz,
			wiscPkg::opBnez,
			wiscPkg::opBltz,
			wiscPkg::opBgez,
			wiscPkg::opJr,
			wiscPkg::opJalr: imm = imm8Sext;

			wiscPkg::opJ,
			wiscPkg::opJal: imm = disp11Sext;

			// r-format, halt and nop carry no immediate
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/regFileBypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFileBypass #(
	parameter int dataWidth = wiscPkg::dataWidth,
	parameter int regSelWidth = wiscPkg::regSelWidth
) (
	input wire clk,
	input wire rstN,
	input wire [regSelWidth-1:0] rsSel,
	input wire [regSelWidth-1:0] rtSel,
	input wire wbEn,
	input wire [regSelWidth-1:0] wbSel,
	input wire [dataWidth-1:0] wbData,
	output logic [dataWidth-1:0] rsData,
	output logic [dataWidth-1:0] rtData
);

	localparam int regCount = 1 << regSelWidth;

	logic [dataWidth-1:0] regs [regCount];
	logic rsHit;
	logic rtHit;

	// one write port with all registers cleared on reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbSel] <= wbData;
		end
	end

	// write-back in flight to the register being read
	assign rsHit = wbEn && (wbSel == rsSel);
	assign rtHit = wbEn && (wbSel == rtSel);

	// forwarded value wins over the stored one
	assign rsData = rsHit ? wbData : regs[rsSel];
	assign rtData = rtHit ? wbData : regs[rtSel];

	// write-back stage must drive clean values when it writes
	wbSelKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		wbEn |-> !$isunknown(wbSel)
	) else $error("write-back select has unknown bits");

	wbDataKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		wbEn |-> !$isunknown(wbData)
	) else $error("write-back data has unknown bits");

endmodule

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
	parameter int dataWidth = wiscPkg::dataWidth,
	parameter int regSelWidth = wiscPkg::regSelWidth
) (
	input wire clk,
	input wire rstN,
	input wire [wiscPkg::instrWidth-1:0] instr,
	input wire [dataWidth-1:0] pc,
	input wire wbEn,
	input wire [regSelWidth-1:0] wbSel,
	input wire [dataWidth-1:0] wbData,
	output wire [wiscPkg::opWidth-1:0] opcode,
	output wire [dataWidth-1:0] rsData,
	output wire [dataWidth-1:0] rtData,
	output wire [dataWidth-1:0] imm,
	output wire [wiscPkg::functWidth-1:0] aluOp,
	output wire [dataWidth-1:0] pcOut,
	output wire memRead,
	output wire memWrite,
	output wire regWrite,
	output wire [regSelWidth-1:0] writeSel,
	output wire savePC,
	output wire halt,
	output wire nop
);

	// read selects from the decoder into the register file
	wire [regSelWidth-1:0] rsSel;
	wire [regSelWidth-1:0] rtSel;

	// pc rides along for the branch and link logic downstream
	assign pcOut = pc;

	instrDecoder decoder (
		.instr(instr),
		.opcode(opcode),
		.rsSel(rsSel),
		.rtSel(rtSel),
		.writeSel(writeSel),
		.aluOp(aluOp),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.savePC(savePC),
		.halt(halt),
		.nop(nop)
	);

	immGen #(
		.dataWidth(dataWidth)
	) immediate (
		.instr(instr),
		.imm(imm)
	);

	// write-back port comes straight from the later stage
	regFileBypass #(
		.dataWidth(dataWidth),
		.regSelWidth(regSelWidth)
	) regFile (
		.clk(clk),
		.rstN(rstN),
		.rsSel(rsSel),
		.rtSel(rtSel),
		.wbEn(wbEn),
		.wbSel(wbSel),
		.wbData(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

endmodule

`default_nettype wire

// ==== tests/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

	localparam int maxVecs = 64;
	localparam int vecWidth = 84;
	localparam string vecFile = "tests/decodeTests.txt";

	logic clk;
	logic rstN;
	logic [15:0] instr;
	logic [15:0] pc;
	logic wbEn;
	logic [2:0] wbSel;
	logic [15:0] wbData;

	wire [4:0] opcode;
	wire [15:0] rsData;
	wire [15:0] rtData;
	wire [15:0] imm;
	wire [1:0] aluOp;
	wire [15:0] pcOut;
	wire memRead;
	wire memWrite;
	wire regWrite;
	wire [2:0] writeSel;
	wire savePC;
	wire halt;
	wire nop;

	// one vector per entry, fields as in the data file header
	logic [vecWidth-1:0] vecs [maxVecs];
	// register contents as the write-back stage sees them
	logic [15:0] model [8];

	int errors;
	int vecCount;
	int cycleCount = 0;
	int timeoutLimit = 50;

	decodeStage uut (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.wbEn(wbEn),
		.wbSel(wbSel),
		.wbData(wbData),
		.opcode(opcode),
		.rsData(rsData),
		.rtData(rtData),
		.imm(imm),
		.aluOp(aluOp),
		.pcOut(pcOut),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.writeSel(writeSel),
		.savePC(savePC),
		.halt(halt),
		.nop(nop)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("timeout: run did not finish within %0d cycles", timeoutLimit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic reportMismatch(input int vecIdx, input string what,
			input logic [15:0] got, input logic [15:0] exp);
		errors++;
		$display("[FAIL] t=%0t: vector %0d %s is %h, expected %h",
			$time, vecIdx, what, got, exp);
	endtask

	initial begin
		int unsigned rnd;
		logic [3:0] kind;
		logic [2:0] rsSel;
		logic [2:0] rtSel;
		logic [15:0] expRs;
		logic [15:0] expRt;
		logic [15:0] expImm;
		logic [2:0] expWriteSel;
		logic [5:0] expCtrl;
		logic [5:0] gotCtrl;

		rstN = 1'b0;
		instr = 16'h0800;
		pc = '0;
		wbEn = 1'b0;
		wbSel = '0;
		wbData = '0;
		errors = 0;
		for (int i = 0; i < 8; i++) begin
			model[i] = '0;
		end

		$readmemh(vecFile, vecs);
		// a kind outside 1..3 ends the list
		vecCount = 0;
		while (vecCount < maxVecs && vecs[vecCount][83:80] inside {4'h1, 4'h2, 4'h3}) begin
			vecCount++;
		end
		timeoutLimit = vecCount * 4 + 50;
		if (vecCount == 0) begin
			errors++;
			$display("no test vectors could be read from %s", vecFile);
		end

		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
		void'($urandom(32'h2cd25a25));

		for (int n = 0; n < vecCount; n++) begin
			@(posedge clk);
			#1;
			kind = vecs[n][83:80];
			wbEn = (kind != 4'h2);
			wbSel = vecs[n][78:76];
			wbData = vecs[n][75:60];
			if (kind == 4'h1) begin
				// write-back only, the word being decoded is a don't care
				rnd = $urandom();
				instr = rnd[15:0];
				pc = rnd[31:16];
			end else begin
				instr = vecs[n][59:44];
				pc = vecs[n][43:28];
			end
			expImm = vecs[n][27:12];
			expWriteSel = vecs[n][10:8];
			expCtrl = vecs[n][5:0];

			// settle mid-cycle, well clear of both edges
			#5;
			if (kind != 4'h1) begin
				rsSel = instr[10:8];
				rtSel = instr[7:5];
				expRs = (wbEn && wbSel == rsSel) ? wbData : model[rsSel];
				expRt = (wbEn && wbSel == rtSel) ? wbData : model[rtSel];
				gotCtrl = {memRead, memWrite, regWrite, savePC, halt, nop};

				if (opcode !== instr[15:11])
					reportMismatch(n, "opcode", {11'b0, opcode}, {11'b0, instr[15:11]});
				if (aluOp !== instr[1:0])
					reportMismatch(n, "aluOp", {14'b0, aluOp}, {14'b0, instr[1:0]});
				if (pcOut !== pc)
					reportMismatch(n, "pcOut", pcOut, pc);
				if (imm !== expImm)
					reportMismatch(n, "imm", imm, expImm);
				if (gotCtrl !== expCtrl)
					reportMismatch(n, "control {memRead,memWrite,regWrite,savePC,halt,nop}",
						{10'b0, gotCtrl}, {10'b0, expCtrl});
				// destination only matters when something is written
				if (expCtrl[3] && writeSel !== expWriteSel)
					reportMismatch(n, "writeSel", {13'b0, writeSel}, {13'b0, expWriteSel});
				if (rsData !== expRs)
					reportMismatch(n, "rsData", rsData, expRs);
				if (rtData !== expRt)
					reportMismatch(n, "rtData", rtData, expRt);
			end
			// lands in the array on the coming edge
			if (wbEn) begin
				model[wbSel] = wbData;
			end
		end

		@(posedge clk);
		#1;
		wbEn = 1'b0;
		@(posedge clk);
		$display("decodeStageTb done: %0d vectors, %0d errors", vecCount, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/decodeTests.txt ====
// kind_wbSel_wbData_instr_pc_expImm_expWriteSel_expCtrl
// kind 1 write-back only, 2 decode only, 3 write-back and decode together, 0 ends the list
// expCtrl bits 5:0 are memRead memWrite regWrite savePC halt nop
// registers still at reset value
2_0_0000_D9A5_0010_0000_1_08
2_0_0000_0000_0012_0000_0_02
2_0_0000_0800_0014_0000_0_01
// load the register file
1_1_1234_0000_0000_0000_0_00
1_2_ABCD_0000_0000_0000_0_00
1_7_8001_0000_0000_0000_0_00
1_5_0F0F_0000_0000_0000_0_00
// i-format 1
2_0_0000_416F_0100_000F_3_08
2_0_0000_4295_0102_FFF5_4_08
2_0_0000_554A_0104_000A_2_08
2_0_0000_51DF_0106_001F_6_08
2_0_0000_5AF1_0108_0011_7_08
2_0_0000_5803_010A_0003_0_08
2_0_0000_A1A4_010C_0004_5_08
2_0_0000_AA3C_010E_FFFC_1_08
2_0_0000_BC7E_0110_FFFE_3_08
// memory
2_0_0000_8538_0200_FFF8_0_10
2_0_0000_8942_0202_0002_2_28
2_0_0000_9F53_0204_FFF3_7_18
// byte immediates
2_0_0000_937F_0300_007F_3_08
2_0_0000_96A5_0302_00A5_6_08
2_0_0000_C412_0304_0012_4_08
2_0_0000_C580_0306_FF80_5_08
// branches and jumps
2_0_0000_6120_0400_0020_0_00
2_0_0000_6AF0_0402_FFF0_0_00
2_0_0000_23FF_0404_03FF_0_00
2_0_0000_2401_0406_FC01_0_00
2_0_0000_37FE_0408_FFFE_7_0C
2_0_0000_2904_040A_0004_0_00
2_0_0000_3AFC_040C_FFFC_7_0C
// register-register
2_0_0000_CF0C_0500_0000_3_08
2_0_0000_E15C_0502_0000_7_08
2_0_0000_F029_0504_0000_2_08
2_0_0000_FB96_0506_0000_5_08
// same-cycle write-back and read
3_3_5A5A_DB30_0600_0000_4_08
2_0_0000_4300_0602_0000_0_08
3_1_0BAD_8225_0604_0005_0_10
3_6_C0DE_E6C4_0606_0000_1_08
2_0_0000_CE28_0608_0000_2_08
0_0_0000_0000_0000_0000_0_00

// ==== sources.f ====
hw/wiscPkg.sv
hw/instrDecoder.sv
hw/immGen.sv
hw/regFileBypass.sv
hw/decodeStage.sv
tests/decodeStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= decodeStageTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TESTDATA ?= tests/decodeTests.txt
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a listed source or the list itself changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(TESTDATA)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
